//--- hw/core_ctrl_defs.svh
`ifndef CORE_CTRL_DEFS_SVH
`define CORE_CTRL_DEFS_SVH

// data path width in bits
`define CC_XLEN 32

// byte address width
`define CC_AWIDTH 32

// data memory depth in words, 1 KiB total
`define CC_MEM_WORDS 256

// base read latency of the data memory, cycles
`define CC_RD_WAIT 1

`endif

//--- hw/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    // AXI4-Lite response codes, only the two the memory uses
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // retirement controller states
    typedef enum logic {
        IDLE = 1'b0,    // new request may be taken
        WAIT = 1'b1     // divide or load in flight
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/stall_ctrl.sv
`default_nettype none

`include "core_ctrl_defs.svh"

module stall_ctrl (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           reg_we_i,         // regfile write request
    input  wire                           csr_we_i,         // csr write request
    input  wire                           mem_en_i,         // load or store pending
    input  wire                           mem_we_i,         // 1 = store
    input  wire  [`CC_XLEN/8-1:0]         mem_wstrb_i,
    input  wire  [`CC_AWIDTH-1:0]         mem_addr_i,
    input  wire  [`CC_XLEN-1:0]           mem_wdata_i,
    input  wire                           div_start_i,
    input  wire                           div_ready_i,
    input  wire                           iram_busy_i,      // fetch side not ready
    input  wire                           trap_in_i,        // trap entry in progress
    input  wire                           trap_jump_i,      // last step of trap entry
    input  wire                           mret_i,
    output logic                          retire_o,
    output logic                          reg_we_o,
    output logic                          csr_we_o,
    output logic                          fetch_en_o,
    output logic                          trap_active_o,
    output logic                          access_fault_o,
    output logic [`CC_XLEN-1:0]           mem_rdata_o,
    output logic [`CC_AWIDTH-1:0]         axi_awaddr_o,
    output logic [2:0]                    axi_awprot_o,
    output logic                          axi_awvalid_o,
    input  wire                           axi_awready_i,
    output logic [`CC_XLEN-1:0]           axi_wdata_o,
    output logic [`CC_XLEN/8-1:0]         axi_wstrb_o,
    output logic                          axi_wvalid_o,
    input  wire                           axi_wready_i,
    input  wire  core_ctrl_pkg::axi_resp_t axi_bresp_i,
    input  wire                           axi_bvalid_i,
    output logic                          axi_bready_o,
    output logic [`CC_AWIDTH-1:0]         axi_araddr_o,
    output logic [2:0]                    axi_arprot_o,
    output logic                          axi_arvalid_o,
    input  wire                           axi_arready_i,
    input  wire  [`CC_XLEN-1:0]           axi_rdata_i,
    input  wire  core_ctrl_pkg::axi_resp_t axi_rresp_i,
    input  wire                           axi_rvalid_i,
    output logic                          axi_rready_o
);

    import core_ctrl_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        req_ok;        // bus request allowed this cycle
    logic        wr_hs;         // AW and W both accepted
    logic        rd_hs;
    logic        r_done;
    logic        r_ok;
    logic        r_err;
    logic        load_req;
    logic        store_req;

    assign load_req  = mem_en_i & ~mem_we_i;
    assign store_req = mem_en_i & mem_we_i;
    assign req_ok    = (state_q == IDLE) & ~trap_in_i & ~iram_busy_i;

    assign wr_hs  = axi_awvalid_o & axi_awready_i & axi_wvalid_o & axi_wready_i;
    assign rd_hs  = axi_arvalid_o & axi_arready_i;
    assign r_done = axi_rvalid_i & axi_rready_o;
    assign r_ok   = r_done & (axi_rresp_i == OKAY);
    assign r_err  = r_done & (axi_rresp_i != OKAY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        if (state_q == IDLE) begin
            if (!trap_in_i && (div_start_i || rd_hs)) begin
                state_d = WAIT;     // divide running or load issued
            end
        end else begin
            // error response also leaves, the fault is reported instead
            if (div_ready_i || trap_in_i || r_done) begin
                state_d = IDLE;
            end
        end
    end

    always_comb begin
        if (state_q == IDLE) begin
            retire_o = ~trap_in_i & ~iram_busy_i & ~div_start_i & ~load_req
                     & ~(store_req & ~wr_hs);
        end else begin
            retire_o = ~trap_in_i & (div_ready_i | r_ok);
        end
    end

    assign access_fault_o = (state_q == WAIT) & ~trap_in_i & r_err;

    // write gating, fetch stays open on a trap jump
    assign reg_we_o   = retire_o & reg_we_i;
    assign csr_we_o   = retire_o & csr_we_i;
    assign fetch_en_o = retire_o | trap_jump_i;

    assign mem_rdata_o = ((state_q == WAIT) && r_ok) ? axi_rdata_i : '0;

    assign axi_awprot_o = 3'b000;
    assign axi_arprot_o = 3'b000;
    assign axi_bready_o = 1'b1;
    assign axi_rready_o = 1'b1;

    always_comb begin
        axi_awaddr_o  = '0;
        axi_wdata_o   = '0;
        axi_wstrb_o   = '0;
        axi_araddr_o  = '0;
        axi_awvalid_o = 1'b0;
        axi_wvalid_o  = 1'b0;
        axi_arvalid_o = 1'b0;
        if (state_q == IDLE) begin
            axi_awaddr_o  = mem_addr_i;
            axi_wdata_o   = mem_wdata_i;
            axi_wstrb_o   = mem_wstrb_i;
            axi_araddr_o  = mem_addr_i;
            axi_awvalid_o = req_ok & store_req;     // stores only
            axi_wvalid_o  = req_ok & store_req;
            axi_arvalid_o = req_ok & load_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trap_active_o <= 1'b0;
        end else if (!trap_active_o) begin
            if (trap_jump_i) begin
                trap_active_o <= 1'b1;      // handler entered
            end
        end else if (mret_i && retire_o) begin
            trap_active_o <= 1'b0;          // mret retired
        end
    end

    a_one_channel: assert property (@(posedge clk) disable iff (!rst_n)
        !(axi_awvalid_o && axi_arvalid_o));

    a_no_req_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == WAIT) |-> !(axi_awvalid_o || axi_wvalid_o || axi_arvalid_o));

    // stores are only issued inside the memory range
    a_bresp_okay: assert property (@(posedge clk) disable iff (!rst_n)
        axi_bvalid_i |-> (axi_bresp_i == OKAY));

endmodule

`default_nettype wire

//--- hw/seq_divider.sv
`default_nettype none

`include "core_ctrl_defs.svh"

module seq_divider (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start_i,
    input  wire  [`CC_XLEN-1:0]  dividend_i,
    input  wire  [`CC_XLEN-1:0]  divisor_i,
    output logic [`CC_XLEN-1:0]  quot_o,
    output logic [`CC_XLEN-1:0]  rem_o,
    output logic                 ready_o
);

    localparam int CNT_W = $clog2(`CC_XLEN);

    logic                busy_q;
    logic                done_q;
    logic [CNT_W-1:0]    cnt_q;       // step index
    logic [`CC_XLEN-1:0] rem_q;
    logic [`CC_XLEN-1:0] quot_q;      // dividend shifts out, quotient in
    logic [`CC_XLEN-1:0] dvsr_q;
    logic [`CC_XLEN:0]   partial;
    logic [`CC_XLEN:0]   diff;
    logic                fits;

    // one restoring step; a zero divisor always fits, which leaves
    // all ones in the quotient and the dividend in the remainder
    assign partial = {rem_q, quot_q[`CC_XLEN-1]};
    assign diff    = partial - {1'b0, dvsr_q};
    assign fits    = ~diff[`CC_XLEN];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(`CC_XLEN - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;     // ready 33 cycles after start
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rem_q  <= '0;
            quot_q <= dividend_i;
            dvsr_q <= divisor_i;
        end else if (busy_q) begin
            rem_q  <= fits ? diff[`CC_XLEN-1:0] : partial[`CC_XLEN-1:0];
            quot_q <= {quot_q[`CC_XLEN-2:0], fits};
        end
    end

    assign quot_o  = quot_q;
    assign rem_o   = rem_q;
    assign ready_o = done_q;

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        busy_q |-> !start_i);

endmodule

`default_nettype wire

//--- hw/axil_data_mem.sv
`default_nettype none

`include "core_ctrl_defs.svh"

module axil_data_mem (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire  [`CC_AWIDTH-1:0]          awaddr_i,
    input  wire                            awvalid_i,
    output logic                           awready_o,
    input  wire  [`CC_XLEN-1:0]            wdata_i,
    input  wire  [`CC_XLEN/8-1:0]          wstrb_i,
    input  wire                            wvalid_i,
    output logic                           wready_o,
    output core_ctrl_pkg::axi_resp_t       bresp_o,
    output logic                           bvalid_o,
    input  wire                            bready_i,
    input  wire  [`CC_AWIDTH-1:0]          araddr_i,
    input  wire                            arvalid_i,
    output logic                           arready_o,
    output logic [`CC_XLEN-1:0]            rdata_o,
    output core_ctrl_pkg::axi_resp_t       rresp_o,
    output logic                           rvalid_o,
    input  wire                            rready_i
);

    import core_ctrl_pkg::*;

    localparam int IDX_W = $clog2(`CC_MEM_WORDS);
    localparam logic [`CC_AWIDTH-1:0] MEM_BYTES = `CC_AWIDTH'(`CC_MEM_WORDS * 4);

    logic [`CC_XLEN-1:0] mem_q [`CC_MEM_WORDS];
    logic                wr_fire;
    logic                wr_in_range;
    logic [IDX_W-1:0]    wr_idx;
    logic                rd_busy_q;     // read accepted, response not yet taken
    logic [3:0]          rd_cnt_q;      // cycles left until rvalid
    logic [IDX_W-1:0]    rd_idx_q;
    logic                rd_ok_q;
    logic                bvalid_q;
    axi_resp_t           bresp_q;

    assign wr_in_range = (awaddr_i < MEM_BYTES);
    assign wr_idx      = awaddr_i[IDX_W+1:2];

    // both write channels accepted together, and only with no read in flight
    assign wr_fire   = awvalid_i & wvalid_i & ~rd_busy_q & (~bvalid_q | bready_i);
    assign awready_o = wr_fire;
    assign wready_o  = wr_fire;
    assign bvalid_o  = bvalid_q;
    assign bresp_o   = bresp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CC_MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_fire && wr_in_range) begin
            for (int b = 0; b < `CC_XLEN / 8; b++) begin
                if (wstrb_i[b]) begin
                    mem_q[wr_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
            bresp_q  <= OKAY;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_in_range ? OKAY : SLVERR;    // bad address dropped
        end else if (bready_i) begin
            bvalid_q <= 1'b0;
        end
    end

    assign arready_o = ~rd_busy_q;
    assign rvalid_o  = rd_busy_q & (rd_cnt_q == 4'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy_q <= 1'b0;
            rd_cnt_q  <= '0;
            rd_ok_q   <= 1'b0;
            rd_idx_q  <= '0;
        end else if (!rd_busy_q) begin
            if (arvalid_i) begin
                rd_busy_q <= 1'b1;
                // wait grows with the word offset inside a 16-byte line
                rd_cnt_q  <= 4'(`CC_RD_WAIT) + {2'b00, araddr_i[3:2]};
                rd_ok_q   <= (araddr_i < MEM_BYTES);
                rd_idx_q  <= araddr_i[IDX_W+1:2];
            end
        end else if (rvalid_o) begin
            if (rready_i) begin
                rd_busy_q <= 1'b0;
            end
        end else begin
            rd_cnt_q <= rd_cnt_q - 1'b1;
        end
    end

    assign rdata_o = (rvalid_o && rd_ok_q) ? mem_q[rd_idx_q] : '0;
    assign rresp_o = rd_ok_q ? OKAY : SLVERR;

endmodule

`default_nettype wire

//--- hw/core_ctrl_top.sv
`default_nettype none

`include "core_ctrl_defs.svh"

module core_ctrl_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    reg_we_i,
    input  wire                    csr_we_i,
    input  wire                    mem_en_i,
    input  wire                    mem_we_i,
    input  wire  [`CC_XLEN/8-1:0]  mem_wstrb_i,
    input  wire  [`CC_AWIDTH-1:0]  mem_addr_i,
    input  wire  [`CC_XLEN-1:0]    mem_wdata_i,
    input  wire                    div_start_i,
    input  wire  [`CC_XLEN-1:0]    div_dividend_i,
    input  wire  [`CC_XLEN-1:0]    div_divisor_i,
    input  wire                    iram_busy_i,
    input  wire                    trap_in_i,
    input  wire                    trap_jump_i,
    input  wire                    mret_i,
    output logic                   retire_o,
    output logic                   reg_we_o,
    output logic                   csr_we_o,
    output logic                   fetch_en_o,
    output logic                   trap_active_o,
    output logic                   access_fault_o,
    output logic [`CC_XLEN-1:0]    mem_rdata_o,
    output logic [`CC_XLEN-1:0]    div_quot_o,
    output logic [`CC_XLEN-1:0]    div_rem_o
);

    import core_ctrl_pkg::*;

    logic                  div_ready;
    logic [`CC_AWIDTH-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [`CC_XLEN-1:0]   wdata;
    logic [`CC_XLEN/8-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    axi_resp_t             bresp;
    logic                  bvalid;
    logic                  bready;
    logic [`CC_AWIDTH-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [`CC_XLEN-1:0]   rdata;
    axi_resp_t             rresp;
    logic                  rvalid;
    logic                  rready;

    stall_ctrl stall_ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_we_i       (reg_we_i),
        .csr_we_i       (csr_we_i),
        .mem_en_i       (mem_en_i),
        .mem_we_i       (mem_we_i),
        .mem_wstrb_i    (mem_wstrb_i),
        .mem_addr_i     (mem_addr_i),
        .mem_wdata_i    (mem_wdata_i),
        .div_start_i    (div_start_i),
        .div_ready_i    (div_ready),
        .iram_busy_i    (iram_busy_i),
        .trap_in_i      (trap_in_i),
        .trap_jump_i    (trap_jump_i),
        .mret_i         (mret_i),
        .retire_o       (retire_o),
        .reg_we_o       (reg_we_o),
        .csr_we_o       (csr_we_o),
        .fetch_en_o     (fetch_en_o),
        .trap_active_o  (trap_active_o),
        .access_fault_o (access_fault_o),
        .mem_rdata_o    (mem_rdata_o),
        .axi_awaddr_o   (awaddr),
        .axi_awprot_o   (),             // memory ignores protection
        .axi_awvalid_o  (awvalid),
        .axi_awready_i  (awready),
        .axi_wdata_o    (wdata),
        .axi_wstrb_o    (wstrb),
        .axi_wvalid_o   (wvalid),
        .axi_wready_i   (wready),
        .axi_bresp_i    (bresp),
        .axi_bvalid_i   (bvalid),
        .axi_bready_o   (bready),
        .axi_araddr_o   (araddr),
        .axi_arprot_o   (),
        .axi_arvalid_o  (arvalid),
        .axi_arready_i  (arready),
        .axi_rdata_i    (rdata),
        .axi_rresp_i    (rresp),
        .axi_rvalid_i   (rvalid),
        .axi_rready_o   (rready)
    );

    seq_divider seq_divider_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (div_start_i),
        .dividend_i (div_dividend_i),
        .divisor_i  (div_divisor_i),
        .quot_o     (div_quot_o),
        .rem_o      (div_rem_o),
        .ready_o    (div_ready)
    );

    axil_data_mem axil_data_mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready)
    );

endmodule

`default_nettype wire

//--- test/core_ctrl_tb.sv
`default_nettype none

`include "core_ctrl_defs.svh"

module core_ctrl_tb;

    localparam int N_ROWS = 24;

    typedef enum logic [2:0] {
        K_ALU, K_STORE, K_LOAD, K_LOAD_ERR, K_DIV, K_TRAP, K_ABORT
    } kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] dividend;
        logic [31:0] divisor;
        logic        reg_we;
        logic        csr_we;
        logic        mret;
        logic [3:0]  stall;        // iram busy cycles before retire
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  reg_we_i, csr_we_i, mem_en_i, mem_we_i;
    logic [`CC_XLEN/8-1:0] mem_wstrb_i;
    logic [`CC_AWIDTH-1:0] mem_addr_i;
    logic [`CC_XLEN-1:0]   mem_wdata_i, div_dividend_i, div_divisor_i;
    logic                  div_start_i, iram_busy_i, trap_in_i, trap_jump_i, mret_i;
    logic                  retire_o, reg_we_o, csr_we_o, fetch_en_o;
    logic                  trap_active_o, access_fault_o;
    logic [`CC_XLEN-1:0]   mem_rdata_o, div_quot_o, div_rem_o;

    logic [31:0] shadow [`CC_MEM_WORDS];    // expected memory contents
    logic [31:0] wa [4];                    // word addresses used by the rows
    row_t        tbl [N_ROWS];
    logic        trap_act_exp;

    core_ctrl_top core_ctrl_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(N_ROWS * 64 * 8);
        $display("timeout: a table row did not retire or fault within its cycle budget");
        $display("Simulation failed");
        $fatal(1);
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // nothing may retire or write while stalled
    task automatic check_stalled();
        check_bit("retire_o", retire_o, 1'b0);
        check_bit("reg_we_o", reg_we_o, 1'b0);
        check_bit("csr_we_o", csr_we_o, 1'b0);
        check_bit("fetch_en_o", fetch_en_o, trap_jump_i);
    endtask

    // handler flag rises after a trap jump and falls after a retired mret
    task automatic step_trap_model(input logic exp_retire);
        if (!trap_act_exp && trap_jump_i) begin
            trap_act_exp = 1'b1;
        end else if (trap_act_exp && mret_i && exp_retire) begin
            trap_act_exp = 1'b0;
        end
    endtask

    task automatic drive_idle();
        reg_we_i       <= 1'b0;
        csr_we_i       <= 1'b0;
        mem_en_i       <= 1'b0;
        mem_we_i       <= 1'b0;
        mem_wstrb_i    <= '0;
        mem_addr_i     <= '0;
        mem_wdata_i    <= '0;
        div_start_i    <= 1'b0;
        div_dividend_i <= '0;
        div_divisor_i  <= '0;
        iram_busy_i    <= 1'b0;
        trap_in_i      <= 1'b0;
        trap_jump_i    <= 1'b0;
        mret_i         <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            drive_idle();
            @(negedge clk);
            // an empty slot retires at once when nothing is pending
            check_bit("retire_o", retire_o, 1'b1);
            check_bit("trap_active_o", trap_active_o, trap_act_exp);
            check_bit("access_fault_o", access_fault_o, 1'b0);
            step_trap_model(1'b1);
        end
    endtask

    function automatic row_t make_row(input kind_t kind, input logic [31:0] addr,
                                      input logic [31:0] data, input logic [3:0] strb,
                                      input logic [31:0] dvd, input logic [31:0] dvs,
                                      input logic [2:0] flags, input logic [3:0] stall);
        row_t r;
        r.kind     = kind;
        r.addr     = addr;
        r.data     = data;
        r.strb     = strb;
        r.dividend = dvd;
        r.divisor  = dvs;
        r.reg_we   = flags[2];
        r.csr_we   = flags[1];
        r.mret     = flags[0];
        r.stall    = stall;
        return r;
    endfunction

    task automatic build_table();
        for (int w = 0; w < `CC_MEM_WORDS; w++) begin
            shadow[w] = '0;
        end
        for (int k = 0; k < 4; k++) begin
            wa[k] = {22'd0, k[1:0], 6'($urandom_range(63)), 2'b00};    // distinct words
        end
        tbl[0]  = make_row(K_ALU, 0, 0, 4'h0, 0, 0, 3'b110, 4'd0);
        tbl[1]  = make_row(K_ALU, 0, 0, 4'h0, 0, 0, 3'b110, 4'd3);
        tbl[2]  = make_row(K_STORE, wa[0], $urandom(), 4'hf, 0, 0, 3'b000, 4'd0);
        tbl[3]  = make_row(K_STORE, wa[0], $urandom(), 4'h5, 0, 0, 3'b000, 4'd0);
        tbl[4]  = make_row(K_STORE, wa[1], $urandom(), 4'h8, 0, 0, 3'b000, 4'd0);
        tbl[5]  = make_row(K_STORE, wa[2], $urandom(), 4'h3, 0, 0, 3'b010, 4'd0);
        tbl[6]  = make_row(K_LOAD, wa[0], 0, 4'h0, 0, 0, 3'b110, 4'd0);
        tbl[7]  = make_row(K_LOAD, wa[1], 0, 4'h0, 0, 0, 3'b100, 4'd0);
        tbl[8]  = make_row(K_LOAD, wa[2], 0, 4'h0, 0, 0, 3'b110, 4'd0);
        tbl[9]  = make_row(K_LOAD, wa[3], 0, 4'h0, 0, 0, 3'b100, 4'd0);    // never written
        tbl[10] = make_row(K_LOAD_ERR, 32'h400 + 32'($urandom_range(255)) * 4, 0, 4'h0,
                           0, 0, 3'b110, 4'd0);
        tbl[11] = make_row(K_LOAD, wa[0], 0, 4'h0, 0, 0, 3'b100, 4'd0);
        tbl[12] = make_row(K_LOAD_ERR, 32'h8000_000c, 0, 4'h0, 0, 0, 3'b100, 4'd0);
        tbl[13] = make_row(K_DIV, 0, 0, 4'h0, $urandom(), 32'd1 + $urandom_range(65534),
                           3'b100, 4'd0);
        tbl[14] = make_row(K_DIV, 0, 0, 4'h0, $urandom(), 0, 3'b110, 4'd0);
        tbl[15] = make_row(K_DIV, 0, 0, 4'h0, 7, 32'hffff_ffff, 3'b100, 4'd0);
        tbl[16] = make_row(K_TRAP, 0, 0, 4'h0, 0, 0, 3'b110, 4'd0);
        tbl[17] = make_row(K_ALU, 0, 0, 4'h0, 0, 0, 3'b010, 4'd2);    // inside handler
        tbl[18] = make_row(K_ABORT, {wa[1][31:4], 4'hc}, 0, 4'h0, 0, 0, 3'b110, 4'd0);
        tbl[19] = make_row(K_LOAD, wa[1], 0, 4'h0, 0, 0, 3'b100, 4'd0);
        tbl[20] = make_row(K_ALU, 0, 0, 4'h0, 0, 0, 3'b011, 4'd1);    // mret after a stall
        tbl[21] = make_row(K_STORE, wa[3], $urandom(), 4'hf, 0, 0, 3'b000, 4'd0);
        tbl[22] = make_row(K_LOAD, wa[3], 0, 4'h0, 0, 0, 3'b110, 4'd0);
        tbl[23] = make_row(K_DIV, 0, 0, 4'h0, $urandom(), 32'd1 + $urandom_range(9),
                           3'b110, 4'd0);
    endtask

    task automatic run_row(input row_t r);
        int          cyc;
        int          lat;
        logic        done;
        logic [31:0] q_exp;
        logic [31:0] r_exp;
        @(posedge clk);
        reg_we_i       <= r.reg_we;
        csr_we_i       <= r.csr_we;
        mret_i         <= r.mret;
        mem_en_i       <= r.kind inside {K_STORE, K_LOAD, K_LOAD_ERR, K_ABORT};
        mem_we_i       <= (r.kind == K_STORE);
        mem_addr_i     <= r.addr;
        mem_wdata_i    <= r.data;
        mem_wstrb_i    <= r.strb;
        div_start_i    <= (r.kind == K_DIV);
        div_dividend_i <= r.dividend;
        div_divisor_i  <= r.divisor;
        iram_busy_i    <= (r.stall != 0);
        trap_in_i      <= (r.kind == K_TRAP);
        trap_jump_i    <= (r.kind == K_TRAP);
        case (r.kind)
            K_STORE: lat = 0;
            K_LOAD, K_LOAD_ERR, K_ABORT: lat = `CC_RD_WAIT + int'(r.addr[3:2]);
            K_DIV: lat = 33;
            default: lat = int'(r.stall);
        endcase
        if (r.kind == K_TRAP) begin
            @(negedge clk);
            check_bit("trap_active_o", trap_active_o, trap_act_exp);
            check_stalled();
            step_trap_model(1'b0);
        end else if (r.kind == K_ABORT) begin
            @(negedge clk);
            check_stalled();                // load issued and waiting for data
            step_trap_model(1'b0);
            @(posedge clk);
            trap_in_i <= 1'b1;
            @(negedge clk);
            check_stalled();
            step_trap_model(1'b0);
        end else begin
            cyc  = 0;
            done = 1'b0;
            while (!done) begin
                @(negedge clk);
                check_bit("trap_active_o", trap_active_o, trap_act_exp);
                done = retire_o | access_fault_o;
                if (!done) begin
                    check_stalled();
                    step_trap_model(1'b0);
                    @(posedge clk);
                    div_start_i <= 1'b0;    // start is a single pulse
                    if (cyc + 1 >= int'(r.stall)) begin
                        iram_busy_i <= 1'b0;
                    end
                    cyc++;
                end
            end
            check_word("retire_o latency", cyc, lat);
            if (r.kind == K_LOAD_ERR) begin
                check_bit("access_fault_o", access_fault_o, 1'b1);
                check_stalled();
                step_trap_model(1'b0);
            end else begin
                check_bit("retire_o", retire_o, 1'b1);
                check_bit("access_fault_o", access_fault_o, 1'b0);
                check_bit("reg_we_o", reg_we_o, r.reg_we);
                check_bit("csr_we_o", csr_we_o, r.csr_we);
                check_bit("fetch_en_o", fetch_en_o, 1'b1);
                step_trap_model(1'b1);
            end
            if (r.kind == K_LOAD) begin
                check_word("mem_rdata_o", mem_rdata_o, shadow[r.addr[9:2]]);
            end else if (r.kind == K_STORE) begin
                for (int b = 0; b < 4; b++) begin
                    if (r.strb[b]) begin
                        shadow[r.addr[9:2]][b*8 +: 8] = r.data[b*8 +: 8];
                    end
                end
            end else if (r.kind == K_DIV) begin
                if (r.divisor == 0) begin
                    q_exp = '1;             // RISC-V divide by zero
                    r_exp = r.dividend;
                end else begin
                    q_exp = r.dividend / r.divisor;
                    r_exp = r.dividend % r.divisor;
                end
                check_word("div_quot_o", div_quot_o, q_exp);
                check_word("div_rem_o", div_rem_o, r_exp);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h191b_0af9));
        trap_act_exp = 1'b0;
        rst_n = 1'b0;
        drive_idle();
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(tbl[i]);
            // an aborted read still drains inside the memory
            idle_cycles((tbl[i].kind == K_ABORT) ? 6 : 1);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/core_ctrl_pkg.sv
hw/stall_ctrl.sv
hw/seq_divider.sv
hw/axil_data_mem.sv
hw/core_ctrl_top.sv
test/core_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module core_ctrl_tb -o core_ctrl_sim

./obj_dir/core_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
else
    exit 1
fi
